// File: verilog/tg_config.svh
// Widths, memory depth and engine count of the traffic generator
// Register map of one engine block, offsets within the block
`ifndef TG_CONFIG_SVH
`define TG_CONFIG_SVH

`define TG_DATA_W       32
`define TG_ADDR_W       10
`define TG_MEM_DEPTH    1024
`define TG_NUM_ENG      2
`define TG_REG_ADDR_W   5

// Each engine owns a block of 8 registers
`define TG_REG_OFF_W    3
`define TG_REG_CTRL     3'd0
`define TG_REG_BASE     3'd1
`define TG_REG_LEN      3'd2
`define TG_REG_SEED     3'd3
`define TG_REG_STATUS   3'd4
`define TG_REG_ERRCNT   3'd5

`endif

// File: verilog/tg_pkg.sv
// Types shared by the traffic generator
// Opcode and engine state enums
package tg_pkg;

        // Bit 1 of the CTRL register
        typedef enum logic {
                TG_OP_WRITE = 1'b0,
                TG_OP_CHECK = 1'b1
        } tg_op_e;

        typedef enum logic [1:0] {
                TG_IDLE  = 2'd0,
                TG_ISSUE = 2'd1,
                TG_DRAIN = 2'd2,
                TG_DONE  = 2'd3
        } tg_state_e;

endpackage

// File: verilog/tg_cfg_regs.sv
// Host register file of the traffic generator
// Programming registers, start pulses and done sticky bits per engine
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_cfg_regs import tg_pkg::*; (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            cfg_we,
        input  logic                            cfg_re,
        input  logic [`TG_REG_ADDR_W-1:0]       cfg_addr,
        input  logic [`TG_DATA_W-1:0]           cfg_wdata,
        output logic [`TG_DATA_W-1:0]           cfg_rdata,
        output logic                            cfg_rvalid,
        output logic [`TG_NUM_ENG-1:0]          start,
        output tg_op_e                          op [`TG_NUM_ENG],
        output logic [`TG_ADDR_W-1:0]           base [`TG_NUM_ENG],
        output logic [`TG_ADDR_W:0]             len [`TG_NUM_ENG],
        output logic [`TG_DATA_W-1:0]           seed [`TG_NUM_ENG],
        input  logic [`TG_NUM_ENG-1:0]          busy,
        input  logic [`TG_NUM_ENG-1:0]          done,
        input  logic [`TG_DATA_W-1:0]           err_cnt [`TG_NUM_ENG]
);
        localparam int BLK_W = `TG_REG_ADDR_W - `TG_REG_OFF_W;

        logic [BLK_W-1:0]               blk;
        logic [`TG_REG_OFF_W-1:0]       off;
        logic [`TG_DATA_W-1:0]          base_q [`TG_NUM_ENG];
        logic [`TG_DATA_W-1:0]          len_q [`TG_NUM_ENG];
        logic [`TG_NUM_ENG-1:0]         done_q;
        logic [`TG_DATA_W-1:0]          rd_val;

        assign blk = cfg_addr[`TG_REG_ADDR_W-1:`TG_REG_OFF_W];
        assign off = cfg_addr[`TG_REG_OFF_W-1:0];

        // Start and done sticky, a start is dropped while the engine runs
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        start  <= '0;
                        done_q <= '0;
                        for (int e = 0; e < `TG_NUM_ENG; e++)
                                op[e] <= TG_OP_WRITE;
                end else begin
                        for (int e = 0; e < `TG_NUM_ENG; e++) begin
                                start[e] <= 1'b0;
                                if (done[e])
                                        done_q[e] <= 1'b1;
                                if (cfg_we && blk == BLK_W'(e) && off == `TG_REG_CTRL &&
                                    cfg_wdata[0] && !busy[e] && !start[e]) begin
                                        start[e]  <= 1'b1;
                                        op[e]     <= tg_op_e'(cfg_wdata[1]);
                                        done_q[e] <= 1'b0;
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int e = 0; e < `TG_NUM_ENG; e++) begin
                        if (cfg_we && blk == BLK_W'(e)) begin
                                case (off)
                                `TG_REG_BASE: base_q[e] <= cfg_wdata;
                                `TG_REG_LEN:  len_q[e]  <= cfg_wdata;
                                `TG_REG_SEED: seed[e]   <= cfg_wdata;
                                default: ;
                                endcase
                        end
                end
        end

        // Engines only see the address and count bits they use
        always_comb begin
                for (int e = 0; e < `TG_NUM_ENG; e++) begin
                        base[e] = base_q[e][`TG_ADDR_W-1:0];
                        len[e]  = len_q[e][`TG_ADDR_W:0];
                end
        end

        always_comb begin
                rd_val = '0;
                for (int e = 0; e < `TG_NUM_ENG; e++) begin
                        if (blk == BLK_W'(e)) begin
                                case (off)
                                `TG_REG_CTRL:   rd_val = {30'd0, op[e], 1'b0};
                                `TG_REG_BASE:   rd_val = base_q[e];
                                `TG_REG_LEN:    rd_val = len_q[e];
                                `TG_REG_SEED:   rd_val = seed[e];
                                // Busy covers the cycle between start and the engine
                                `TG_REG_STATUS: rd_val = {30'd0, done_q[e], busy[e] | start[e]};
                                `TG_REG_ERRCNT: rd_val = err_cnt[e];
                                default:        rd_val = '0;
                                endcase
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        cfg_rvalid <= 1'b0;
                else
                        cfg_rvalid <= cfg_re;
        end

        always_ff @(posedge clk) begin
                if (cfg_re)
                        cfg_rdata <= rd_val;
        end

endmodule

// File: verilog/tg_engine.sv
// Traffic generator engine
// Writes an xorshift pattern over a region, or reads it back
// and counts the words that differ from the regenerated pattern
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_engine import tg_pkg::*; (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    start,
        input  tg_op_e                  op,
        input  logic [`TG_ADDR_W-1:0]   base,
        input  logic [`TG_ADDR_W:0]     len,
        input  logic [`TG_DATA_W-1:0]   seed,
        output logic                    busy,
        output logic                    done,
        output logic [`TG_DATA_W-1:0]   err_cnt,
        output logic                    mem_req,
        output logic                    mem_we,
        output logic [`TG_ADDR_W-1:0]   mem_addr,
        output logic [`TG_DATA_W-1:0]   mem_wdata,
        input  logic                    mem_gnt,
        input  logic                    mem_rvalid,
        input  logic [`TG_DATA_W-1:0]   mem_rdata
);
        tg_state_e              state;
        tg_op_e                 op_q;
        logic [`TG_ADDR_W:0]    issue_left;
        logic [`TG_ADDR_W:0]    ret_left;
        logic [`TG_ADDR_W-1:0]  addr_q;
        logic [`TG_DATA_W-1:0]  issue_val;
        logic [`TG_DATA_W-1:0]  exp_val;
        logic                   launch;

        // xorshift32, shifts 13, 17, 5
        function automatic logic [`TG_DATA_W-1:0] xs_next(input logic [`TG_DATA_W-1:0] v);
                logic [`TG_DATA_W-1:0] t;
                t = v ^ (v << 13);
                t = t ^ (t >> 17);
                t = t ^ (t << 5);
                return t;
        endfunction

        assign launch = start && (state == TG_IDLE || state == TG_DONE);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state      <= TG_IDLE;
                        op_q       <= TG_OP_WRITE;
                        issue_left <= '0;
                        ret_left   <= '0;
                        err_cnt    <= '0;
                end else begin
                        // Check data can come back while reads are still issued
                        if (mem_rvalid) begin
                                ret_left <= ret_left - 1'b1;
                                if (mem_rdata != exp_val)
                                        err_cnt <= err_cnt + 1'b1;
                        end
                        case (state)
                        TG_IDLE, TG_DONE: begin
                                state <= TG_IDLE;
                                if (launch) begin
                                        op_q       <= op;
                                        issue_left <= len;
                                        ret_left   <= len;
                                        err_cnt    <= '0;
                                        state      <= (len == '0) ? TG_DONE : TG_ISSUE;
                                end
                        end
                        TG_ISSUE: begin
                                if (mem_gnt) begin
                                        issue_left <= issue_left - 1'b1;
                                        if (issue_left == 1)
                                                state <= (op_q == TG_OP_WRITE) ? TG_DONE : TG_DRAIN;
                                end
                        end
                        TG_DRAIN: begin
                                if (mem_rvalid && ret_left == 1)
                                        state <= TG_DONE;
                        end
                        default: state <= TG_IDLE;
                        endcase
                end
        end

        // Issue side steps on grants, expect side on returned reads
        always_ff @(posedge clk) begin
                if (launch) begin
                        addr_q    <= base;
                        issue_val <= seed;
                        exp_val   <= seed;
                end else begin
                        if (state == TG_ISSUE && mem_gnt) begin
                                addr_q    <= addr_q + 1'b1;
                                issue_val <= xs_next(issue_val);
                        end
                        if (mem_rvalid)
                                exp_val <= xs_next(exp_val);
                end
        end

        assign mem_req   = (state == TG_ISSUE);
        assign mem_we    = (op_q == TG_OP_WRITE);
        assign mem_addr  = addr_q;
        assign mem_wdata = issue_val;
        assign busy      = (state == TG_ISSUE) || (state == TG_DRAIN);
        assign done      = (state == TG_DONE);

endmodule

// File: verilog/tg_mem_arbiter.sv
// Round-robin arbiter of the engines onto the scratch memory
// Steers read data back by the registered grant owner
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_mem_arbiter (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [`TG_NUM_ENG-1:0]  eng_req,
        input  logic [`TG_NUM_ENG-1:0]  eng_we,
        input  logic [`TG_ADDR_W-1:0]   eng_addr [`TG_NUM_ENG],
        input  logic [`TG_DATA_W-1:0]   eng_wdata [`TG_NUM_ENG],
        output logic [`TG_NUM_ENG-1:0]  eng_gnt,
        output logic [`TG_NUM_ENG-1:0]  eng_rvalid,
        output logic [`TG_DATA_W-1:0]   eng_rdata,
        output logic                    mem_en,
        output logic                    mem_we,
        output logic [`TG_ADDR_W-1:0]   mem_addr,
        output logic [`TG_DATA_W-1:0]   mem_wdata,
        input  logic [`TG_DATA_W-1:0]   mem_rdata
);
        localparam int IW = $clog2(`TG_NUM_ENG);

        logic [IW-1:0]  sel;
        logic [IW-1:0]  last_q;
        logic [IW-1:0]  owner_q;
        logic           rd_q;

        // Search starts just past the last granted engine
        always_comb begin
                int idx;
                eng_gnt = '0;
                sel     = last_q;
                for (int k = 1; k <= `TG_NUM_ENG; k++) begin
                        idx = (int'(last_q) + k) % `TG_NUM_ENG;
                        if (eng_req[idx] && eng_gnt == '0) begin
                                eng_gnt[idx] = 1'b1;
                                sel          = IW'(idx);
                        end
                end
        end

        assign mem_en    = |eng_gnt;
        assign mem_we    = eng_we[sel];
        assign mem_addr  = eng_addr[sel];
        assign mem_wdata = eng_wdata[sel];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        last_q  <= '0;
                        owner_q <= '0;
                        rd_q    <= 1'b0;
                end else begin
                        rd_q <= mem_en && !mem_we;
                        if (mem_en) begin
                                last_q  <= sel;
                                owner_q <= sel;
                        end
                end
        end

        always_comb begin
                eng_rvalid          = '0;
                eng_rvalid[owner_q] = rd_q;
        end

        assign eng_rdata = mem_rdata;

endmodule

// File: verilog/tg_scratch_mem.sv
// Single-port scratch memory
// Registered read data, one cycle after enable
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_scratch_mem (
        input  logic                    clk,
        input  logic                    en,
        input  logic                    we,
        input  logic [`TG_ADDR_W-1:0]   addr,
        input  logic [`TG_DATA_W-1:0]   wdata,
        output logic [`TG_DATA_W-1:0]   rdata
);
        logic [`TG_DATA_W-1:0] mem [`TG_MEM_DEPTH];

        always_ff @(posedge clk) begin
                if (en) begin
                        if (we)
                                mem[addr] <= wdata;
                        // Read-before-write on the same address
                        rdata <= mem[addr];
                end
        end

endmodule

// File: verilog/tg_top.sv
// Traffic generator subsystem top level
// Register block, two engines, arbiter and scratch memory
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_top import tg_pkg::*; (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            cfg_we,
        input  logic                            cfg_re,
        input  logic [`TG_REG_ADDR_W-1:0]       cfg_addr,
        input  logic [`TG_DATA_W-1:0]           cfg_wdata,
        output logic [`TG_DATA_W-1:0]           cfg_rdata,
        output logic                            cfg_rvalid,
        output logic [`TG_NUM_ENG-1:0]          done
);
        logic [`TG_NUM_ENG-1:0] eng_start;
        tg_op_e                 eng_op [`TG_NUM_ENG];
        logic [`TG_ADDR_W-1:0]  eng_base [`TG_NUM_ENG];
        logic [`TG_ADDR_W:0]    eng_len [`TG_NUM_ENG];
        logic [`TG_DATA_W-1:0]  eng_seed [`TG_NUM_ENG];
        logic [`TG_NUM_ENG-1:0] eng_busy;
        logic [`TG_DATA_W-1:0]  eng_err [`TG_NUM_ENG];

        logic [`TG_NUM_ENG-1:0] eng_req;
        logic [`TG_NUM_ENG-1:0] eng_we;
        logic [`TG_ADDR_W-1:0]  eng_addr [`TG_NUM_ENG];
        logic [`TG_DATA_W-1:0]  eng_wdata [`TG_NUM_ENG];
        logic [`TG_NUM_ENG-1:0] eng_gnt;
        logic [`TG_NUM_ENG-1:0] eng_rvalid;
        logic [`TG_DATA_W-1:0]  eng_rdata;

        logic                   mem_en;
        logic                   mem_we;
        logic [`TG_ADDR_W-1:0]  mem_addr;
        logic [`TG_DATA_W-1:0]  mem_wdata;
        logic [`TG_DATA_W-1:0]  mem_rdata;

        tg_cfg_regs i_cfg_regs (
                .clk        ( clk        ),
                .rst_n      ( rst_n      ),
                .cfg_we     ( cfg_we     ),
                .cfg_re     ( cfg_re     ),
                .cfg_addr   ( cfg_addr   ),
                .cfg_wdata  ( cfg_wdata  ),
                .cfg_rdata  ( cfg_rdata  ),
                .cfg_rvalid ( cfg_rvalid ),
                .start      ( eng_start  ),
                .op         ( eng_op     ),
                .base       ( eng_base   ),
                .len        ( eng_len    ),
                .seed       ( eng_seed   ),
                .busy       ( eng_busy   ),
                .done       ( done       ),
                .err_cnt    ( eng_err    )
        );

        for (genvar g = 0; g < `TG_NUM_ENG; g++) begin : g_eng
                tg_engine i_engine (
                        .clk        ( clk           ),
                        .rst_n      ( rst_n         ),
                        .start      ( eng_start[g]  ),
                        .op         ( eng_op[g]     ),
                        .base       ( eng_base[g]   ),
                        .len        ( eng_len[g]    ),
                        .seed       ( eng_seed[g]   ),
                        .busy       ( eng_busy[g]   ),
                        .done       ( done[g]       ),
                        .err_cnt    ( eng_err[g]    ),
                        .mem_req    ( eng_req[g]    ),
                        .mem_we     ( eng_we[g]     ),
                        .mem_addr   ( eng_addr[g]   ),
                        .mem_wdata  ( eng_wdata[g]  ),
                        .mem_gnt    ( eng_gnt[g]    ),
                        .mem_rvalid ( eng_rvalid[g] ),
                        .mem_rdata  ( eng_rdata     )
                );
        end

        tg_mem_arbiter i_arbiter (
                .clk        ( clk        ),
                .rst_n      ( rst_n      ),
                .eng_req    ( eng_req    ),
                .eng_we     ( eng_we     ),
                .eng_addr   ( eng_addr   ),
                .eng_wdata  ( eng_wdata  ),
                .eng_gnt    ( eng_gnt    ),
                .eng_rvalid ( eng_rvalid ),
                .eng_rdata  ( eng_rdata  ),
                .mem_en     ( mem_en     ),
                .mem_we     ( mem_we     ),
                .mem_addr   ( mem_addr   ),
                .mem_wdata  ( mem_wdata  ),
                .mem_rdata  ( mem_rdata  )
        );

        tg_scratch_mem i_scratch_mem (
                .clk   ( clk       ),
                .en    ( mem_en    ),
                .we    ( mem_we    ),
                .addr  ( mem_addr  ),
                .wdata ( mem_wdata ),
                .rdata ( mem_rdata )
        );

endmodule

// File: verification/tg_checker.sv
// Monitor of the register read port and the done pulses
// Compares read data with values queued by the testbench model
`timescale 1ns/1ps
`include "tg_config.svh"

module tg_checker (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic [`TG_DATA_W-1:0]   cfg_rdata,
        input  logic                    cfg_rvalid,
        input  logic [`TG_NUM_ENG-1:0]  done
);
        string                  rd_name_q [$];
        logic [`TG_DATA_W-1:0]  rd_exp_q [$];
        int                     done_cnt [`TG_NUM_ENG];
        int                     done_exp [`TG_NUM_ENG];
        int                     data_errs = 0;
        int                     done_errs = 0;

        initial begin
                for (int e = 0; e < `TG_NUM_ENG; e++) begin
                        done_cnt[e] = 0;
                        done_exp[e] = 0;
                end
        end

        task automatic expect_read(input string name, input logic [`TG_DATA_W-1:0] exp);
                rd_name_q.push_back(name);
                rd_exp_q.push_back(exp);
        endtask

        task automatic expect_done(input int e);
                done_exp[e]++;
        endtask

        task automatic missing_done(input int e, input string name);
                $display("%s: engine %0d raised no done pulse in time", name, e);
                done_errs++;
        endtask

        // All watched outputs are registered, stable at the falling edge
        always @(negedge clk) begin
                string                  name;
                logic [`TG_DATA_W-1:0]  exp;
                if (rst_n) begin
                        if (cfg_rvalid) begin
                                if (rd_exp_q.size() == 0) begin
                                        $display("Read data came back with no read outstanding");
                                        data_errs++;
                                end else begin
                                        name = rd_name_q.pop_front();
                                        exp  = rd_exp_q.pop_front();
                                        if (cfg_rdata !== exp) begin
                                                $display("ERR %s expected 0x%08h actual 0x%08h",
                                                         name, exp, cfg_rdata);
                                                data_errs++;
                                        end
                                end
                        end
                        for (int e = 0; e < `TG_NUM_ENG; e++) begin
                                if (done[e]) begin
                                        done_cnt[e]++;
                                        if (done_cnt[e] > done_exp[e]) begin
                                                $display("Engine %0d gave a done pulse without a start", e);
                                                done_errs++;
                                        end
                                end
                        end
                end
        end

        task automatic final_check();
                if (rd_exp_q.size() != 0) begin
                        $display("%0d register reads never returned data", rd_exp_q.size());
                        data_errs++;
                end
                for (int e = 0; e < `TG_NUM_ENG; e++) begin
                        if (done_cnt[e] != done_exp[e]) begin
                                $display("Engine %0d gave %0d done pulses where %0d were due",
                                         e, done_cnt[e], done_exp[e]);
                                done_errs++;
                        end
                end
        endtask

endmodule

// File: verification/tb_tg_top.sv
// Testbench of the traffic generator subsystem
// Clock, reset, watchdog, xorshift stimulus and the shadow memory model
`timescale 1ns/1ps
`include "tg_config.svh"

module tb_tg_top import tg_pkg::*; ();
        localparam int NE        = `TG_NUM_ENG;
        localparam int DEPTH     = `TG_MEM_DEPTH;
        localparam int WD_MARGIN = 3000;

        logic                           clk;
        logic                           rst_n;
        logic                           cfg_we;
        logic                           cfg_re;
        logic [`TG_REG_ADDR_W-1:0]      cfg_addr;
        logic [`TG_DATA_W-1:0]          cfg_wdata;
        logic [`TG_DATA_W-1:0]          cfg_rdata;
        logic                           cfg_rvalid;
        logic [NE-1:0]                  done;

        logic [31:0]    rnd_state;
        logic [31:0]    shadow [DEPTH];
        tg_op_e         cur_op [NE];
        int             cur_base [NE];
        int             cur_len [NE];
        logic [31:0]    cur_seed [NE];
        int             done_target [NE];
        int             words_total = 0;
        int             cycles;

        tg_top dut (.*);
        tg_checker chk (.*);

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // Budget grows with every word handed to an engine
        initial begin
                cycles = 0;
                while (cycles <= 4 * words_total + WD_MARGIN) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Watchdog expired after %0d cycles, the tests did not complete", cycles);
                $display("Result: FAILED");
                $finish;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] v);
                logic [31:0] t;
                t = v ^ (v << 13);
                t = t ^ (t >> 17);
                return t ^ (t << 5);
        endfunction

        function automatic logic [31:0] rand32();
                rnd_state = xorshift32(rnd_state);
                return rnd_state;
        endfunction

        task automatic model_write(input int e);
                logic [31:0] v;
                v = cur_seed[e];
                for (int i = 0; i < cur_len[e]; i++) begin
                        shadow[(cur_base[e] + i) % DEPTH] = v;
                        v = xorshift32(v);
                end
        endtask

        // Mismatches a check of the current region would find
        function automatic int model_count(input int e);
                logic [31:0] v;
                int          cnt;
                v   = cur_seed[e];
                cnt = 0;
                for (int i = 0; i < cur_len[e]; i++) begin
                        if (shadow[(cur_base[e] + i) % DEPTH] != v)
                                cnt++;
                        v = xorshift32(v);
                end
                return cnt;
        endfunction

        task automatic reg_write(input int e, input int off, input logic [31:0] data);
                cfg_we    = 1'b1;
                cfg_addr  = `TG_REG_ADDR_W'(e * 8 + off);
                cfg_wdata = data;
                @(negedge clk);
                cfg_we    = 1'b0;
        endtask

        task automatic reg_read(input int e, input int off, input logic [31:0] exp,
                                input string name);
                chk.expect_read($sformatf("%s reg %0d.%0d", name, e, off), exp);
                cfg_re   = 1'b1;
                cfg_addr = `TG_REG_ADDR_W'(e * 8 + off);
                @(negedge clk);
                cfg_re   = 1'b0;
        endtask

        task automatic start_op(input int e, input tg_op_e op, input int base, input int len,
                                input logic [31:0] seed);
                reg_write(e, `TG_REG_BASE, base);
                reg_write(e, `TG_REG_LEN, len);
                reg_write(e, `TG_REG_SEED, seed);
                cur_op[e]   = op;
                cur_base[e] = base;
                cur_len[e]  = len;
                cur_seed[e] = seed;
                words_total += len;
        endtask

        task automatic kick(input int e);
                done_target[e]++;
                chk.expect_done(e);
                reg_write(e, `TG_REG_CTRL, {30'd0, cur_op[e], 1'b1});
        endtask

        task automatic wait_done(input int e, input string name);
                int n;
                n = 0;
                do begin
                        @(posedge clk);
                        n++;
                end while (chk.done_cnt[e] < done_target[e] && n < 4 * cur_len[e] + 64);
                if (chk.done_cnt[e] < done_target[e])
                        chk.missing_done(e, name);
                @(negedge clk);
        endtask

        task automatic finish_op(input int e, input string name);
                wait_done(e, name);
                if (cur_op[e] == TG_OP_WRITE)
                        model_write(e);
                reg_read(e, `TG_REG_ERRCNT, (cur_op[e] == TG_OP_WRITE) ? 0 : model_count(e),
                         name);
                // Done sticky set, busy clear
                reg_read(e, `TG_REG_STATUS, 32'h2, name);
        endtask

        task automatic run_op(input int e, input tg_op_e op, input int base, input int len,
                              input logic [31:0] seed, input string name);
                start_op(e, op, base, len, seed);
                kick(e);
                finish_op(e, name);
        endtask

        initial begin
                int             b;
                int             l;
                int             gap;
                int             b1;
                int             l1;
                logic [31:0]    s;
                rst_n     = 1'b0;
                cfg_we    = 1'b0;
                cfg_re    = 1'b0;
                cfg_addr  = '0;
                cfg_wdata = '0;
                rnd_state = 32'h575dc6ce;
                for (int e = 0; e < NE; e++)
                        done_target[e] = 0;
                repeat (16) @(negedge clk);
                rst_n = 1'b1;
                @(negedge clk);

                for (int e = 0; e < NE; e++) begin
                        reg_read(e, `TG_REG_STATUS, 0, "reset");
                        reg_read(e, `TG_REG_CTRL, 0, "reset");
                        reg_read(e, `TG_REG_ERRCNT, 0, "reset");
                        for (int k = 0; k < 3; k++) begin
                                for (int off = `TG_REG_BASE; off <= `TG_REG_SEED; off++) begin
                                        s = rand32();
                                        reg_write(e, off, s);
                                        reg_read(e, off, s, "readback");
                                end
                        end
                end

                // Whole memory written once so no check reads an unwritten word
                run_op(0, TG_OP_WRITE, 0, DEPTH, rand32(), "preload");

                for (int k = 0; k < 4; k++) begin
                        b = int'(rand32() % DEPTH);
                        l = 1 + int'(rand32() % 128);
                        s = rand32();
                        run_op(k % NE, TG_OP_WRITE, b, l, s, "write_check");
                        run_op(k % NE, TG_OP_CHECK, b, l, s, "write_check");
                end

                for (int k = 0; k < 3; k++) begin
                        b = int'(rand32() % DEPTH);
                        l = 1 + int'(rand32() % 128);
                        run_op(k % NE, TG_OP_WRITE, b, l, rand32(), "seed_mismatch");
                        run_op(k % NE, TG_OP_CHECK, b, l, rand32(), "seed_mismatch");
                end

                // Two disjoint regions written at once under arbitration
                b   = int'(rand32() % DEPTH);
                l   = 1 + int'(rand32() % 128);
                gap = int'(rand32() % 64);
                b1  = (b + l + gap) % DEPTH;
                l1  = 1 + int'(rand32() % 128);
                start_op(0, TG_OP_WRITE, b, l, rand32());
                start_op(1, TG_OP_WRITE, b1, l1, rand32());
                kick(0);
                kick(1);
                finish_op(0, "dual_write");
                finish_op(1, "dual_write");

                s = cur_seed[0];
                start_op(0, TG_OP_CHECK, b1, l1, s);
                start_op(1, TG_OP_CHECK, b, l, cur_seed[1]);
                kick(0);
                kick(1);
                finish_op(0, "cross_check");
                finish_op(1, "cross_check");

                // Engine 0 spans both regions and the gap between them
                start_op(0, TG_OP_CHECK, b, l + gap + l1, s);
                start_op(1, TG_OP_CHECK, b1, l1, cur_seed[1]);
                kick(0);
                kick(1);
                finish_op(0, "span_check");
                finish_op(1, "span_check");

                // Second start while the engine is busy
                b = int'(rand32() % DEPTH);
                l = 32 + int'(rand32() % 64);
                start_op(0, TG_OP_CHECK, b, l, rand32());
                kick(0);
                @(negedge clk);
                reg_write(0, `TG_REG_CTRL, {30'd0, TG_OP_WRITE, 1'b1});
                // Done sticky cleared by the accepted start, engine still running
                reg_read(0, `TG_REG_STATUS, 32'h1, "busy_start");
                finish_op(0, "busy_start");
                reg_read(0, `TG_REG_CTRL, {30'd0, TG_OP_CHECK, 1'b0}, "busy_start");

                run_op(0, TG_OP_CHECK, int'(rand32() % DEPTH), 0, rand32(), "zero_len");

                repeat (20) @(negedge clk);
                chk.final_check();
                $display("Errors: %0d total, %0d data, %0d done",
                         chk.data_errs + chk.done_errs, chk.data_errs, chk.done_errs);
                if (chk.data_errs + chk.done_errs == 0)
                        $display("Result: PASSED");
                else
                        $display("Result: FAILED");
                $finish;
        end

endmodule

// File: tg_subsys.f
+incdir+verilog
verilog/tg_pkg.sv
verilog/tg_cfg_regs.sv
verilog/tg_engine.sv
verilog/tg_mem_arbiter.sv
verilog/tg_scratch_mem.sv
verilog/tg_top.sv
verification/tg_checker.sv
verification/tb_tg_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the traffic generator testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_tg_top -f tg_subsys.f > build.log 2>&1 \
        && ./obj_dir/Vtb_tg_top > sim.log 2>&1 \
        || { echo "Build or run failed, see build.log and sim.log"; exit 1; }
grep -qx "Result: PASSED" sim.log \
        && echo "Simulation passed" \
        || { echo "Simulation failed, see sim.log"; exit 1; }
